/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_linkSpi -Mdir obj_dir -f vlog.f
	obj_dir/Vtb_linkSpi +verilator+error+limit+1000 | \
		awk '{ print } /^test passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* hdl/linkFrameDecoder.sv */
`timescale 1ns/10ps

`include "linkSpi_settings.svh"

module linkFrameDecoder import linkSpiPkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  linkWord_t headWord,
	input  logic      notEmpty,
	input  logic      dataHold,
	output logic      pop,
	output linkWord_t busData,
	output logic      busStrobe,
	output logic      sysReset,
	output logic      frameOk,
	output logic      frameBad,
	output linkByte_t frameCmd
);

	decodeState_t state;

	linkWord_t sum;         // running sum of frame words
	linkByte_t remaining;   // data words still to come
	linkByte_t cmd;         // command of current frame
	logic      addrMatch;   // frame is for this terminal

	linkByte_t headHigh;
	linkByte_t headLow;
	logic      sumOk;

	assign headHigh = headWord[`LINK_WORD_W-1 -: 8];
	assign headLow  = headWord[7:0];
	assign sumOk    = (headWord == sum);

	// one word per cycle unless the bus side holds us
	assign pop = notEmpty & ~dataHold;

	// frame walk
	always_ff @(posedge clk)
	begin
		if (rst)
			state <= ST_ADDR;
		else if (pop)
		begin
			unique case (state)
				ST_ADDR:
					state <= ST_SIZE_CMD;
				ST_SIZE_CMD:
				begin
					if (headHigh == '0)
						state <= ST_SUM;  // no data words
					else
						state <= ST_DATA;
				end
				ST_DATA:
				begin
					if (remaining == 8'd1)
						state <= ST_SUM;
				end
				ST_SUM:
					state <= ST_WORD_NUM;
				ST_WORD_NUM:
					state <= ST_ADDR;
				default:
					state <= ST_ADDR;
			endcase
		end
	end

	// frame context, only meaningful inside a frame
	always_ff @(posedge clk)
	begin
		if (rst)
			addrMatch <= 1'b0;
		else if (pop && state == ST_ADDR)
			addrMatch <= (headHigh == `LINK_ADDR);

		if (pop)
		begin
			case (state)
				ST_ADDR:
					sum <= headWord;  // checksum restarts
				ST_SIZE_CMD:
				begin
					sum       <= sum + headWord;
					remaining <= headHigh;
					cmd       <= headLow;
				end
				ST_DATA:
				begin
					sum       <= sum + headWord;
					remaining <= remaining - 1'b1;
				end
				default:
					sum <= sum;
			endcase
		end
	end

	// outputs, one cycle after the pop that causes them
	always_ff @(posedge clk)
	begin
		busStrobe <= 1'b0;
		sysReset  <= 1'b0;
		frameOk   <= 1'b0;
		frameBad  <= 1'b0;
		if (!rst && pop && addrMatch)
		begin
			if (state == ST_DATA && cmd == CMD_TRANSMIT)
			begin
				busStrobe <= 1'b1;
				busData   <= headWord;  // forwarded regardless of checksum
			end
			if (state == ST_SUM)
			begin
				frameOk  <= sumOk;
				frameBad <= ~sumOk;
				frameCmd <= cmd;  // held until next verdict
				sysReset <= sumOk && (cmd == CMD_RESET);
			end
		end
	end

endmodule

/* hdl/linkSpiPkg.sv */
`include "linkSpi_settings.svh"

package linkSpiPkg;

	typedef logic [`LINK_WORD_W-1:0] linkWord_t;   // one spi link word
	typedef logic [7:0] linkByte_t;                 // address, size or command field

	// command codes, low byte of the size/command word
	localparam linkByte_t CMD_RESET    = 8'hA0;     // system reset
	localparam linkByte_t CMD_TRANSMIT = 8'hA2;     // data words go to the bus
	localparam linkByte_t CMD_STATUS   = 8'hB0;     // status request
	localparam linkByte_t CMD_RECEIVE  = 8'hB2;     // read back received data

	// frame decoder states in frame order
	typedef enum logic [2:0]
	{
		ST_ADDR,      // address word
		ST_SIZE_CMD,  // size in high byte, command in low byte
		ST_DATA,      // size data words
		ST_SUM,       // checksum of all previous words
		ST_WORD_NUM   // trailing word, discarded
	} decodeState_t;

endpackage

/* hdl/linkSpiTop.sv */
`timescale 1ns/10ps

module linkSpiTop import linkSpiPkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      sclk,
	input  logic      csN,
	input  logic      mosi,
	input  logic      dataHold,
	output linkWord_t busData,
	output logic      busStrobe,
	output logic      sysReset,
	output logic      frameOk,
	output logic      frameBad,
	output linkByte_t frameCmd,
	output logic      overflow
);

	linkWord_t rxWord;
	logic      rxStrobe;
	linkWord_t headWord;
	logic      notEmpty;
	logic      pop;

	spiWordReceiver receiver
	(
		.clk      (clk),
		.rst      (rst),
		.sclk     (sclk),
		.csN      (csN),
		.mosi     (mosi),
		.rxWord   (rxWord),
		.rxStrobe (rxStrobe)
	);

	// no back pressure toward spi
	wordFifo fifo
	(
		.clk      (clk),
		.rst      (rst),
		.wrData   (rxWord),
		.wrStrobe (rxStrobe),
		.pop      (pop),
		.headWord (headWord),
		.notEmpty (notEmpty),
		.overflow (overflow)
	);

	linkFrameDecoder decoder
	(
		.clk       (clk),
		.rst       (rst),
		.headWord  (headWord),
		.notEmpty  (notEmpty),
		.dataHold  (dataHold),
		.pop       (pop),
		.busData   (busData),
		.busStrobe (busStrobe),
		.sysReset  (sysReset),
		.frameOk   (frameOk),
		.frameBad  (frameBad),
		.frameCmd  (frameCmd)
	);

endmodule

/* hdl/linkSpi_settings.svh */
`ifndef LINK_SPI_SETTINGS_SVH
`define LINK_SPI_SETTINGS_SVH

// link word and fifo geometry

`define LINK_WORD_W      16    // bits per spi link word

`define LINK_FIFO_DEPTH  16    // words buffered between spi and decoder

`define LINK_FIFO_AW     4     // pointer width, log2 of depth

// terminal identity on the link

`define LINK_ADDR        8'hAB // matched against high byte of address word

`endif

/* hdl/spiWordReceiver.sv */
`timescale 1ns/10ps

`include "linkSpi_settings.svh"

module spiWordReceiver import linkSpiPkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      sclk,
	input  logic      csN,
	input  logic      mosi,
	output linkWord_t rxWord,
	output logic      rxStrobe
);

	localparam int unsigned CNT_W = $clog2(`LINK_WORD_W);

	logic [1:0] sclkSync;      // two flop synchronizers
	logic [1:0] csSync;
	logic [1:0] mosiSync;
	logic       sclkLast;      // previous synchronized sclk
	logic       sampleEn;      // registered rising edge while selected
	logic       sampleBit;     // mosi aligned with sampleEn
	logic [CNT_W-1:0] bitCnt;  // bits taken in current word
	linkWord_t  shiftReg;

	// pin synchronizers
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sclkSync <= 2'b00;
			csSync   <= 2'b11;  // deselected
			mosiSync <= 2'b00;
		end
		else
		begin
			sclkSync <= {sclkSync[0], sclk};
			csSync   <= {csSync[0], csN};
			mosiSync <= {mosiSync[0], mosi};
		end
	end

	// rising edge of sclk, registered together with the data bit
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sclkLast <= 1'b0;
			sampleEn <= 1'b0;
		end
		else
		begin
			sclkLast <= sclkSync[1];
			sampleEn <= sclkSync[1] & ~sclkLast & ~csSync[1];
		end
		sampleBit <= mosiSync[1];  // payload, follows pin
	end

	// msb first shifter and word strobe
	always_ff @(posedge clk)
	begin
		rxStrobe <= 1'b0;  // pulse only
		if (rst)
			bitCnt <= '0;
		else if (csSync[1])
			bitCnt <= '0;  // word boundary on deselect
		else if (sampleEn)
		begin
			shiftReg <= {shiftReg[`LINK_WORD_W-2:0], sampleBit};
			bitCnt   <= bitCnt + 1'b1;  // wraps after last bit
			if (bitCnt == CNT_W'(`LINK_WORD_W - 1))
				rxStrobe <= 1'b1;
		end
	end

	assign rxWord = shiftReg;  // stable until next sample

endmodule

/* hdl/wordFifo.sv */
`timescale 1ns/10ps

`include "linkSpi_settings.svh"

module wordFifo import linkSpiPkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  linkWord_t wrData,
	input  logic      wrStrobe,
	input  logic      pop,
	output linkWord_t headWord,
	output logic      notEmpty,
	output logic      overflow
);

	linkWord_t mem [`LINK_FIFO_DEPTH];

	logic [`LINK_FIFO_AW-1:0] wrPtr;
	logic [`LINK_FIFO_AW-1:0] rdPtr;
	logic [`LINK_FIFO_AW:0]   count;   // occupancy, one extra bit for full
	logic full;
	logic doWrite;
	logic doPop;

	assign full    = (count == (`LINK_FIFO_AW+1)'(`LINK_FIFO_DEPTH));
	assign doWrite = wrStrobe & ~full;     // full write is dropped
	assign doPop   = pop & notEmpty;       // empty pop is ignored

	// storage
	always_ff @(posedge clk)
	begin
		if (doWrite)
			mem[wrPtr] <= wrData;
	end

	// pointers and occupancy
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;  // wraps at depth
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doWrite, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// sticky until reset
	always_ff @(posedge clk)
	begin
		if (rst)
			overflow <= 1'b0;
		else if (wrStrobe & full)
			overflow <= 1'b1;
	end

	assign notEmpty = (count != '0);
	assign headWord = mem[rdPtr];  // oldest word, show ahead

endmodule

/* verification/linkSpiChecker.sv */
`timescale 1ns/10ps

`include "linkSpi_settings.svh"

module linkSpiChecker import linkSpiPkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      sclk,
	input  logic      csN,
	input  logic      mosi,
	input  linkWord_t busData,
	input  logic      busStrobe,
	input  logic      sysReset,
	input  logic      frameOk,
	input  logic      frameBad,
	input  linkByte_t frameCmd,
	input  logic      overflow,
	output int        errorCount,
	output int        wordsSeen,
	output int        pending
);

	linkWord_t  frame[$];     // words of the frame in progress
	linkWord_t  busQ[$];      // expected transmit words
	logic [8:0] verdictQ[$];  // {ok, cmd} per matching frame
	logic       sclkPrev;
	int         bitCount;
	linkWord_t  shiftWord;
	logic       overflowSeen;

	initial
	begin
		errorCount   = 0;
		wordsSeen    = 0;
		pending      = 0;
		overflowSeen = 1'b0;
	end

	function automatic linkWord_t sumOf(input int count);
		linkWord_t s;
		s = '0;
		for (int i = 0; i < count; i++)
			s += frame[i];  // wraps at 16 bits
		return s;
	endfunction

	// frame rules indexed by word position
	task automatic takeWord(input linkWord_t w);
		int n;
		int size;
		logic match;
		linkByte_t cmd;
		frame.push_back(w);
		n = frame.size();
		if (n >= 2)
		begin
			size  = int'(frame[1][15:8]);
			cmd   = frame[1][7:0];
			match = (frame[0][15:8] == `LINK_ADDR);
			if (match && cmd == CMD_TRANSMIT && n > 2 && n <= size + 2)
				busQ.push_back(w);
			if (match && n == size + 3)
				verdictQ.push_back({w == sumOf(n - 1), cmd});
			if (n == size + 4)
				frame.delete();  // word number word ends it
		end
	endtask

	always @(posedge clk)
	begin
		logic [8:0] v;
		if (rst)
		begin
			sclkPrev = 1'b0;
			bitCount = 0;
			frame.delete();
		end
		else
		begin
			// words rebuilt from the pins msb first on rising sclk
			if (csN)
				bitCount = 0;
			else if (sclk && !sclkPrev)
			begin
				shiftWord = {shiftWord[`LINK_WORD_W-2:0], mosi};
				bitCount++;
				if (bitCount == `LINK_WORD_W)
				begin
					takeWord(shiftWord);
					wordsSeen++;
					bitCount = 0;
				end
			end
			sclkPrev = sclk;

			if (busStrobe)
			begin
				if (busQ.size() == 0)
				begin
					$display("busStrobe pulsed with no transmit word expected");
					errorCount++;
				end
				else if (busQ[0] !== busData)
				begin
					$display("[ERROR] transmit data: expected %h, actual %h", busQ[0], busData);
					errorCount++;
					void'(busQ.pop_front());
				end
				else
					void'(busQ.pop_front());
			end

			if (frameOk && frameBad)
			begin
				$display("frameOk and frameBad pulsed in the same cycle");
				errorCount++;
			end
			else if (frameOk || frameBad)
			begin
				if (verdictQ.size() == 0)
				begin
					$display("frame verdict pulsed with no matching frame pending");
					errorCount++;
				end
				else
				begin
					v = verdictQ.pop_front();
					if (frameOk !== v[8])
					begin
						$display("[ERROR] checksum verdict: expected ok=%b, actual ok=%b",
							v[8], frameOk);
						errorCount++;
					end
					if (frameCmd !== v[7:0])
					begin
						$display("[ERROR] frame command: expected %h, actual %h",
							v[7:0], frameCmd);
						errorCount++;
					end
					if (sysReset !== (v[8] && v[7:0] == CMD_RESET))
					begin
						$display("[ERROR] reset command: expected %b, actual %b",
							v[8] && v[7:0] == CMD_RESET, sysReset);
						errorCount++;
					end
				end
			end
			else if (sysReset)
			begin
				$display("sysReset pulsed outside a frame verdict");
				errorCount++;
			end

			if (overflow && !overflowSeen)
			begin
				$display("word FIFO overflowed and dropped a word");
				errorCount++;
				overflowSeen = 1'b1;
			end
		end
		pending = busQ.size() + verdictQ.size();
	end

endmodule

/* verification/linkSpi_properties.sv */
`timescale 1ns/10ps

module linkSpiProperties import linkSpiPkg::*;
(
	input logic         clk,
	input logic         rst,
	input logic         dataHold,
	input logic         busStrobe,
	input logic         sysReset,
	input logic         frameOk,
	input logic         frameBad,
	input decodeState_t state
);

	int failures = 0;  // failed assertions so far

	// a held cycle pops nothing and so causes no pulse
	holdBlocksOutputs: assert property (@(posedge clk) disable iff (rst)
		dataHold |=> !(busStrobe || frameOk || frameBad))
		else
		begin
			failures++;
			$error("output pulse after a held cycle");
		end

	okBadExclusive: assert property (@(posedge clk) disable iff (rst)
		!(frameOk && frameBad))
		else
		begin
			failures++;
			$error("frameOk and frameBad high together");
		end

	resetWithOk: assert property (@(posedge clk) disable iff (rst)
		sysReset |-> frameOk)
		else
		begin
			failures++;
			$error("sysReset without frameOk");
		end

	// pulses quiet and decoder back at the address word
	quietAfterReset: assert property (@(posedge clk)
		rst |=> !(busStrobe || sysReset || frameOk || frameBad) && state == ST_ADDR)
		else
		begin
			failures++;
			$error("decoder not idle after reset");
		end

endmodule

bind linkFrameDecoder linkSpiProperties props
(
	.clk       (clk),
	.rst       (rst),
	.dataHold  (dataHold),
	.busStrobe (busStrobe),
	.sysReset  (sysReset),
	.frameOk   (frameOk),
	.frameBad  (frameBad),
	.state     (state)
);

/* verification/tb_linkSpi.sv */
`timescale 1ns/10ps

`include "linkSpi_settings.svh"

module tb_linkSpi import linkSpiPkg::*; ();

	localparam int NUM_FRAMES = 60;
	// longest frame is 12 words of 16 bits at 8 clk each plus select overhead
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * 12 * (16 * 8 + 8) + 2000;

	logic      clk;
	logic      rst;
	logic      sclk;
	logic      csN;
	logic      mosi;
	logic      dataHold;
	linkWord_t busData;
	logic      busStrobe;
	logic      sysReset;
	logic      frameOk;
	logic      frameBad;
	linkByte_t frameCmd;
	logic      overflow;
	int        errorCount;
	int        wordsSeen;
	int        pending;

	logic [31:0] lfsr;
	int          holdLeft;
	int          wordsSent;
	int          cycleCount;
	int          totalErrors;

	linkSpiTop DUT (.*);

	linkSpiChecker frameCheck (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois step with taps 32 22 2 1
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrNext(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// one clk edge with random hold stretches of 1 to 10 cycles
	task automatic tick();
		logic [31:0] r;
		@(posedge clk);
		if (holdLeft == 0)
		begin
			r = randBits(3);
			if (r == 0)
			begin
				r        = randBits(4);
				holdLeft = int'(r % 10);
				dataHold <= 1'b1;
			end
			else
				dataHold <= 1'b0;
		end
		else
			holdLeft--;
	endtask

	task automatic sendWord(input linkWord_t w);
		tick();
		csN  <= 1'b0;
		sclk <= 1'b0;
		for (int i = `LINK_WORD_W - 1; i >= 0; i--)
		begin
			tick();
			mosi <= w[i];  // set up half a bit before the rise
			sclk <= 1'b0;
			repeat (3) tick();
			tick();
			sclk <= 1'b1;
			repeat (3) tick();
		end
		tick();
		sclk <= 1'b0;
		tick();
		csN <= 1'b1;
		repeat (2) tick();
		wordsSent++;
	endtask

	task automatic sendFrame(input int index, input logic forceMatch);
		logic [31:0] r;
		linkByte_t   addr;
		linkByte_t   cmd;
		linkByte_t   size;
		linkWord_t   sum;
		linkWord_t   words[$];
		r = randBits(2);
		case (r[1:0])
			2'd0:    cmd = CMD_RESET;
			2'd1:    cmd = CMD_TRANSMIT;
			2'd2:    cmd = CMD_STATUS;
			default: cmd = CMD_RECEIVE;
		endcase
		r    = randBits(2);
		addr = `LINK_ADDR;
		if (r == 0 && !forceMatch)
		begin
			r    = randBits(8);
			addr = r[7:0];
			if (addr == `LINK_ADDR)
				addr ^= 8'h01;  // foreign address
		end
		r    = randBits(4);
		size = 8'(r % 9);
		words.push_back({addr, 8'h00});
		words.push_back({size, cmd});
		for (int i = 0; i < int'(size); i++)
		begin
			r = randBits(16);
			words.push_back(r[15:0]);
		end
		sum = '0;
		foreach (words[i])
			sum += words[i];
		r = randBits(3);
		if (r == 0)
		begin
			r = randBits(4);
			sum[r[3:0]] = ~sum[r[3:0]];  // corrupt checksum
		end
		words.push_back(sum);
		words.push_back(16'(index));
		foreach (words[i])
			sendWord(words[i]);
	endtask

	initial
	begin
		lfsr      = 32'ha57e_0c25;
		holdLeft  = 0;
		wordsSent = 0;
		rst       = 1'b1;
		sclk      = 1'b0;
		csN       = 1'b1;
		mosi      = 1'b0;
		dataHold  = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		for (int f = 0; f < NUM_FRAMES; f++)
			sendFrame(f, f == NUM_FRAMES - 1);  // last frame marks the end
		do
		begin
			@(posedge clk);
			dataHold <= 1'b0;
			@(negedge clk);
		end while (!(wordsSeen == wordsSent && pending == 0));
		totalErrors = errorCount + DUT.decoder.props.failures;
		$display("frames %0d, words %0d, checker errors %0d, assertion failures %0d",
			NUM_FRAMES, wordsSent, errorCount, DUT.decoder.props.failures);
		if (totalErrors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("timeout after %0d cycles, %0d of the words sent, %0d errors so far",
				cycleCount, wordsSent, errorCount);
			$display("test failed");
			$finish;
		end
	end

	initial
		cycleCount = 0;

endmodule

/* vlog.f */
+incdir+hdl
hdl/linkSpiPkg.sv
hdl/spiWordReceiver.sv
hdl/wordFifo.sv
hdl/linkFrameDecoder.sv
hdl/linkSpiTop.sv
verification/linkSpi_properties.sv
verification/linkSpiChecker.sv
verification/tb_linkSpi.sv
